/* hw/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

	localparam int instr_w = 32;
	localparam int addr_w = 32;
	localparam int opcode_w = 6;
	localparam int funct_w = 6;

	// where the opcode and funct fields sit in the instruction word
	localparam int opcode_lsb = 26;
	localparam int funct_lsb = 0;

	localparam logic [opcode_w-1:0] op_rtype = 6'd0;
	localparam logic [opcode_w-1:0] op_j = 6'd2;
	localparam logic [opcode_w-1:0] op_jal = 6'd3;
	localparam logic [opcode_w-1:0] op_beq = 6'd4;
	localparam logic [opcode_w-1:0] op_bne = 6'd5;
	localparam logic [opcode_w-1:0] op_addi = 6'd8;
	localparam logic [opcode_w-1:0] op_slti = 6'd10;
	localparam logic [opcode_w-1:0] op_andi = 6'd12;
	localparam logic [opcode_w-1:0] op_ori = 6'd13;
	localparam logic [opcode_w-1:0] op_xori = 6'd14;
	localparam logic [opcode_w-1:0] op_lui = 6'd15;

	// coprocessor 0 operations use a private encoding, not the MIPS COP0 major opcode
	localparam logic [opcode_w-1:0] op_mfc0 = 6'd16;
	localparam logic [opcode_w-1:0] op_mtc0 = 6'd17;
	localparam logic [opcode_w-1:0] op_eret = 6'd18;

	localparam logic [opcode_w-1:0] op_lw = 6'd35;
	localparam logic [opcode_w-1:0] op_sw = 6'd43;

	localparam logic [funct_w-1:0] fn_jr = 6'd8;
	localparam logic [funct_w-1:0] fn_syscall = 6'd12;

endpackage

`default_nettype wire

/* hw/decode_ctrl_pkg.sv */
`default_nettype none

package decode_ctrl_pkg;

	typedef logic [mips_isa_pkg::addr_w-1:0] pc_t;

	typedef enum logic {
		mode_user = 1'b0,
		mode_kernel = 1'b1
	} cpu_mode_e;

	typedef enum logic [1:0] {
		exc_none = 2'd0,
		exc_ri = 2'd1,
		exc_sys = 2'd2
	} exc_cause_e;

	// one bit per datapath control, the order is the one the later stages expect
	typedef struct packed {
		logic regwrite;
		logic memtoreg;
		logic memread;
		logic memwrite;
		logic isbranch;
		logic isjump;
		logic jumpdst;
		logic islink;
		logic regdst;
		logic aluop;
		logic alu_s;
		logic alu_t;
		logic cowrite;
		logic c0dst;
		logic is_eret;
	} ctrl_word_t;

	typedef struct packed {
		logic [mips_isa_pkg::instr_w-1:0] instr;
		pc_t pc;
	} fetch_pkt_t;

	typedef struct packed {
		pc_t pc;
		ctrl_word_t ctrl;
		exc_cause_e cause;
	} decoded_pkt_t;

endpackage

`default_nettype wire

/* hw/cop0_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface cop0_if;
	import decode_ctrl_pkg::*;

	// handshake between the fetch register and the decoded register
	logic dec_valid;
	logic dec_ready;

	pc_t pc;
	exc_cause_e cause;
	logic is_eret;
	cpu_mode_e cpu_mode;

	modport decoder (
		input cpu_mode,
		output pc, cause, is_eret
	);

	modport status (
		input dec_valid, dec_ready, pc, cause, is_eret,
		output cpu_mode
	);

endinterface

`default_nettype wire

/* hw/pipe_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module pipe_stage #(
	parameter type payload_t = logic
) (
	input wire clk,
	input wire rst_n,
	input wire in_valid,
	output logic in_ready,
	input wire payload_t in_data,
	output logic out_valid,
	input wire out_ready,
	output payload_t out_data
);

	logic valid_q;
	payload_t data_q;
	logic in_fire;

	// a full slot can still take a new beat when the old one leaves this cycle
	assign in_ready = !valid_q || out_ready;
	assign in_fire = in_valid && in_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else if (in_fire) begin
			valid_q <= 1'b1;
		end else if (out_ready) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			data_q <= in_data;
		end
	end

	assign out_valid = valid_q;
	assign out_data = data_q;

endmodule

`default_nettype wire

/* hw/main_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module main_decoder (
	input wire decode_ctrl_pkg::fetch_pkt_t fetch,
	output decode_ctrl_pkg::decoded_pkt_t decoded,
	cop0_if.decoder c0
);
	import mips_isa_pkg::*;
	import decode_ctrl_pkg::*;

	logic [opcode_w-1:0] opcode;
	logic [funct_w-1:0] funct;
	logic kernel;
	ctrl_word_t ctrl;
	exc_cause_e cause;

	assign opcode = fetch.instr[opcode_lsb +: opcode_w];
	assign funct = fetch.instr[funct_lsb +: funct_w];
	assign kernel = (c0.cpu_mode == mode_kernel);

	always_comb begin
		ctrl = '0;
		cause = exc_none;
		case (opcode)
			op_rtype: begin
				case (funct)
					fn_jr: begin
						ctrl.isjump = 1'b1;
						ctrl.jumpdst = 1'b1;
					end
					fn_syscall: begin
						cause = exc_sys;
					end
					default: begin
						ctrl.regwrite = 1'b1;
						ctrl.regdst = 1'b1;
					end
				endcase
			end
			op_addi, op_slti, op_andi, op_ori, op_xori, op_lui: begin
				ctrl.regwrite = 1'b1;
				ctrl.alu_t = 1'b1;
				ctrl.aluop = 1'b1;
			end
			op_lw: begin
				ctrl.regwrite = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.memread = 1'b1;
				ctrl.alu_t = 1'b1;
				ctrl.aluop = 1'b1;
			end
			op_sw: begin
				ctrl.memwrite = 1'b1;
				ctrl.alu_t = 1'b1;
				ctrl.aluop = 1'b1;
			end
			op_j: begin
				ctrl.isjump = 1'b1;
				ctrl.aluop = 1'b1;
			end
			op_jal: begin
				ctrl.regwrite = 1'b1;
				ctrl.isjump = 1'b1;
				ctrl.islink = 1'b1;
				ctrl.aluop = 1'b1;
			end
			op_beq, op_bne: begin
				ctrl.isbranch = 1'b1;
				ctrl.aluop = 1'b1;
			end
			// the privileged group is only legal in kernel mode
			op_mfc0: begin
				ctrl.regwrite = 1'b1;
				ctrl.alu_s = 1'b1;
				ctrl.aluop = 1'b1;
				cause = kernel ? exc_none : exc_ri;
			end
			op_mtc0: begin
				ctrl.c0dst = 1'b1;
				ctrl.cowrite = 1'b1;
				ctrl.aluop = 1'b1;
				cause = kernel ? exc_none : exc_ri;
			end
			op_eret: begin
				ctrl.is_eret = 1'b1;
				cause = kernel ? exc_none : exc_ri;
			end
			default: begin
				cause = exc_ri;
			end
		endcase
	end

	// a faulting instruction carries no datapath controls at all
	assign decoded.pc = fetch.pc;
	assign decoded.ctrl = (cause == exc_none) ? ctrl : '0;
	assign decoded.cause = cause;

	assign c0.pc = fetch.pc;
	assign c0.cause = cause;
	assign c0.is_eret = decoded.ctrl.is_eret;

endmodule

`default_nettype wire

/* hw/cop0_status.sv */
`timescale 1ns/10ps
`default_nettype none

module cop0_status (
	input wire clk,
	input wire rst_n,
	cop0_if.status c0,
	output logic [mips_isa_pkg::addr_w-1:0] epc,
	output decode_ctrl_pkg::cpu_mode_e cpu_mode
);
	import decode_ctrl_pkg::*;

	logic commit;

	// the state only moves when the decoded instruction enters the output register
	assign commit = c0.dec_valid && c0.dec_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cpu_mode <= mode_kernel;
			epc <= '0;
		end else if (commit) begin
			if (c0.cause != exc_none) begin
				cpu_mode <= mode_kernel;
				epc <= c0.pc;
			end else if (c0.is_eret) begin
				cpu_mode <= mode_user;
			end
		end
	end

	assign c0.cpu_mode = cpu_mode;

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
	input wire clk,
	input wire rst_n,
	input wire in_valid,
	output logic in_ready,
	input wire [mips_isa_pkg::instr_w-1:0] in_instr,
	input wire [mips_isa_pkg::addr_w-1:0] in_pc,
	output logic out_valid,
	input wire out_ready,
	output logic [mips_isa_pkg::addr_w-1:0] out_pc,
	output decode_ctrl_pkg::ctrl_word_t out_ctrl,
	output decode_ctrl_pkg::exc_cause_e out_cause,
	output decode_ctrl_pkg::cpu_mode_e cpu_mode,
	output logic [mips_isa_pkg::addr_w-1:0] epc
);
	import decode_ctrl_pkg::*;

	fetch_pkt_t fetch_in;
	fetch_pkt_t fetch_q;
	decoded_pkt_t decoded;
	decoded_pkt_t dec_q;

	cop0_if c0_bus ();

	assign fetch_in.instr = in_instr;
	assign fetch_in.pc = in_pc;

	pipe_stage #(.payload_t(fetch_pkt_t)) u_fetch_reg (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(fetch_in),
		.out_valid(c0_bus.dec_valid),
		.out_ready(c0_bus.dec_ready),
		.out_data(fetch_q)
	);

	main_decoder u_decoder (
		.fetch(fetch_q),
		.decoded(decoded),
		.c0(c0_bus.decoder)
	);

	cop0_status u_cop0 (
		.clk(clk),
		.rst_n(rst_n),
		.c0(c0_bus.status),
		.epc(epc),
		.cpu_mode(cpu_mode)
	);

	pipe_stage #(.payload_t(decoded_pkt_t)) u_dec_reg (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(c0_bus.dec_valid),
		.in_ready(c0_bus.dec_ready),
		.in_data(decoded),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(dec_q)
	);

	assign out_pc = dec_q.pc;
	assign out_ctrl = dec_q.ctrl;
	assign out_cause = dec_q.cause;

endmodule

`default_nettype wire

/* dv/decode_stage_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage_tb;
	import mips_isa_pkg::*;
	import decode_ctrl_pkg::*;

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	logic [31:0] in_instr;
	logic [31:0] in_pc;
	logic out_valid;
	logic out_ready = 1'b1;
	logic [31:0] out_pc;
	ctrl_word_t out_ctrl;
	exc_cause_e out_cause;
	cpu_mode_e cpu_mode;
	logic [31:0] epc;

	logic [31:0] stim_seed = 32'hb8971a03;
	logic [31:0] stall_seed = 32'hb8971a03;
	logic [31:0] next_pc = 32'h0040_0000;
	int stall_pct = 0;
	int errors = 0;
	int checks = 0;
	int start_errors = 0;
	cpu_mode_e ref_mode = mode_kernel;
	logic [31:0] ref_epc = '0;
	decoded_pkt_t exp_q[$];
	logic [32:0] exp_state_q[$];

	// {opcode, funct} pairs: kernel table 0..16, privilege 17..22, syscall and unknown 23..31
	localparam logic [11:0] dir_list [32] = '{
		{op_rtype, 6'd32}, {op_rtype, fn_jr}, {op_addi, 6'd0}, {op_slti, 6'd0},
		{op_andi, 6'd0}, {op_ori, 6'd0}, {op_xori, 6'd0}, {op_lui, 6'd0},
		{op_lw, 6'd0}, {op_sw, 6'd0}, {op_j, 6'd0}, {op_jal, 6'd0},
		{op_beq, 6'd0}, {op_bne, 6'd0}, {op_mfc0, 6'd0}, {op_mtc0, 6'd0},
		{op_rtype, fn_syscall}, {op_eret, 6'd0}, {op_mfc0, 6'd0}, {op_eret, 6'd0},
		{op_mtc0, 6'd0}, {op_eret, 6'd0}, {op_eret, 6'd0}, {op_eret, 6'd0},
		{op_rtype, fn_syscall}, {op_eret, 6'd0}, {op_addi, 6'd0}, {6'd1, 6'd0},
		{op_mfc0, 6'd0}, {op_eret, 6'd0}, {6'd63, 6'd0}, {op_mtc0, 6'd0}
	};

	decode_stage u_decode_stage (.*);

	always #20 clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] seed);
		return seed * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] make_instr(input logic [11:0] op_fn);
		stim_seed = lcg_step(stim_seed);
		return {op_fn[11:6], stim_seed[25:6], op_fn[5:0]};
	endfunction

	// expected decode under the model mode, then the mode and EPC update at commit
	function automatic decoded_pkt_t predict_decode(input logic [31:0] instr, input logic [31:0] pc);
		decoded_pkt_t d;
		logic [5:0] op;
		logic [5:0] fn;
		op = instr[31:26];
		fn = instr[5:0];
		d.pc = pc;
		d.ctrl = '0;
		d.cause = exc_none;
		case (op)
			op_rtype: begin
				if (fn == fn_syscall) begin
					d.cause = exc_sys;
				end else if (fn == fn_jr) begin
					d.ctrl = '{isjump: 1'b1, jumpdst: 1'b1, default: 1'b0};
				end else begin
					d.ctrl = '{regwrite: 1'b1, regdst: 1'b1, default: 1'b0};
				end
			end
			op_addi, op_slti, op_andi, op_ori, op_xori, op_lui:
				d.ctrl = '{regwrite: 1'b1, alu_t: 1'b1, aluop: 1'b1, default: 1'b0};
			op_lw:
				d.ctrl = '{regwrite: 1'b1, memtoreg: 1'b1, memread: 1'b1, alu_t: 1'b1,
					aluop: 1'b1, default: 1'b0};
			op_sw: d.ctrl = '{memwrite: 1'b1, alu_t: 1'b1, aluop: 1'b1, default: 1'b0};
			op_j: d.ctrl = '{isjump: 1'b1, aluop: 1'b1, default: 1'b0};
			op_jal:
				d.ctrl = '{regwrite: 1'b1, isjump: 1'b1, islink: 1'b1, aluop: 1'b1,
					default: 1'b0};
			op_beq, op_bne: d.ctrl = '{isbranch: 1'b1, aluop: 1'b1, default: 1'b0};
			op_mfc0, op_mtc0, op_eret: begin
				if (ref_mode == mode_user) begin
					d.cause = exc_ri;
				end else if (op == op_mfc0) begin
					d.ctrl = '{regwrite: 1'b1, alu_s: 1'b1, aluop: 1'b1, default: 1'b0};
				end else if (op == op_mtc0) begin
					d.ctrl = '{c0dst: 1'b1, cowrite: 1'b1, aluop: 1'b1, default: 1'b0};
				end else begin
					d.ctrl = '{is_eret: 1'b1, default: 1'b0};
				end
			end
			default: d.cause = exc_ri;
		endcase
		if (d.cause != exc_none) begin
			ref_mode = mode_kernel;
			ref_epc = pc;
		end else if (d.ctrl.is_eret) begin
			ref_mode = mode_user;
		end
		return d;
	endfunction

	task automatic report_timeout(input string what);
		errors++;
		$display("timed out at %0t because %s", $time, what);
	endtask

	task automatic send(input logic [31:0] instr, input logic [31:0] pc, input int gap);
		int t;
		repeat (gap) @(negedge clk);
		exp_q.push_back(predict_decode(instr, pc));
		exp_state_q.push_back({ref_mode, ref_epc});
		in_valid = 1'b1;
		in_instr = instr;
		in_pc = pc;
		t = 0;
		do begin
			@(posedge clk);
			t++;
		end while (!in_ready && t < 100);
		if (!in_ready) begin
			report_timeout("in_ready stayed low");
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic drain();
		int t;
		t = 0;
		while (exp_q.size() != 0 && t < 200) begin
			@(negedge clk);
			t++;
		end
		if (exp_q.size() != 0) begin
			report_timeout("expected beats never came out");
			exp_q.delete();
			exp_state_q.delete();
		end
	endtask

	task automatic run_directed(input int first, input int count);
		for (int i = first; i < first + count; i++) begin
			send(make_instr(dir_list[i]), next_pc, 0);
			next_pc = next_pc + 32'd4;
		end
		drain();
	endtask

	task automatic run_random(input int count, input bit with_gaps);
		logic [31:0] instr;
		repeat (count) begin
			stim_seed = lcg_step(stim_seed);
			instr = make_instr(dir_list[stim_seed[28:24]]);
			stim_seed = lcg_step(stim_seed);
			send(instr, {stim_seed[31:2], 2'b00}, with_gaps ? int'(stim_seed[17:16]) : 0);
		end
		drain();
	endtask

	task automatic check_reset();
		checks++;
		assert (!out_valid && in_ready && cpu_mode == mode_kernel && epc == '0) else begin
			errors++;
			$display("FAILED at %0t: reset state out_valid %b in_ready %b mode %0d epc %h",
				$time, out_valid, in_ready, cpu_mode, epc);
		end
	endtask

	task automatic finish_test(input string name);
		if (errors == start_errors) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: %0d errors", name, errors - start_errors);
		end
	endtask

	always @(negedge clk) begin
		stall_seed = lcg_step(stall_seed);
		out_ready = (stall_seed % 32'd100) >= 32'(stall_pct);
	end

	// the mode and EPC seen during the transfer already include this beat's commit
	always @(posedge clk) begin
		decoded_pkt_t e;
		logic [32:0] s;
		if (rst_n && out_valid && out_ready) begin
			checks++;
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("a beat with pc %h came out that was never sent, at %0t", out_pc, $time);
			end
			if (exp_q.size() != 0) begin
				e = exp_q.pop_front();
				s = exp_state_q.pop_front();
				assert (out_pc == e.pc && out_ctrl == e.ctrl && out_cause == e.cause) else begin
					errors++;
					$display("FAILED at %0t: pc %h ctrl %h cause %0d, expected %h %h %0d",
						$time, out_pc, out_ctrl, out_cause, e.pc, e.ctrl, e.cause);
				end
				assert ({cpu_mode, epc} == s) else begin
					errors++;
					$display("FAILED at %0t: pc %h mode %0d epc %h, expected mode %0d epc %h",
						$time, out_pc, cpu_mode, epc, s[32], s[31:0]);
				end
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		in_pc = '0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		check_reset();
		start_errors = errors;
		run_directed(0, 17);
		finish_test("kernel decode table");
		start_errors = errors;
		run_directed(17, 6);
		finish_test("privilege");
		start_errors = errors;
		run_directed(23, 9);
		finish_test("syscall and unknown opcodes");
		@(posedge clk);
		stall_pct = 40;
		@(negedge clk);
		start_errors = errors;
		run_random(60, 1'b1);
		finish_test("ordering under back-pressure");
		@(posedge clk);
		stall_pct = 0;
		@(negedge clk);
		rst_n = 1'b0;
		ref_mode = mode_kernel;
		ref_epc = '0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		start_errors = errors;
		check_reset();
		run_random(30, 1'b0);
		finish_test("reset state and random burst");
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
hw/mips_isa_pkg.sv
hw/decode_ctrl_pkg.sv
hw/cop0_if.sv
hw/pipe_stage.sv
hw/main_decoder.sv
hw/cop0_status.sv
hw/decode_stage.sv
dv/decode_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log for the fail message

cd "$(dirname "$0")" || exit 1
log=sim.log
rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module decode_stage_tb -f project.f -o decode_stage_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/decode_stage_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Something failed" "$log"; then
	exit 1
fi
exit 0
